// ==== hdl/replay_defines.svh ====
// Packet replay widths, depths and thresholds
// Shared by the package and the RTL blocks

`ifndef REPLAY_DEFINES_SVH
`define REPLAY_DEFINES_SVH

`define REPLAY_DATA_W      64
`define REPLAY_KEEP_W      8
// Stored beat is last, keep and data
`define REPLAY_BEAT_W      (1 + `REPLAY_KEEP_W + `REPLAY_DATA_W)

`define REPLAY_ADDR_W      10
`define REPLAY_CNT_W       8

`define REPLAY_FIFO_AW     4
// Free entries at or below which the output FIFO reports nearly full
`define REPLAY_FIFO_SLACK  2

`define REPLAY_SYNC_LEN    3

`endif

// ==== hdl/replay_pkg.sv ====
// Packet replay types
// Vector widths with a meaning and the engine state encoding

`default_nettype none

package replay_pkg;

`include "replay_defines.svh"

   typedef logic [`REPLAY_DATA_W-1:0] data_t;
   typedef logic [`REPLAY_KEEP_W-1:0] keep_t;

   // Last at the top, then keep, then data
   typedef logic [`REPLAY_BEAT_W-1:0] beat_t;

   typedef logic [`REPLAY_ADDR_W-1:0] mem_addr_t;
   typedef logic [`REPLAY_CNT_W-1:0]  replay_cnt_t;

   typedef enum logic [1:0] {
      IDLE,
      CAPTURE,
      REPLAY,
      REPLAY_WRAP
   } engine_state_t;

endpackage

`default_nettype wire

// ==== hdl/replay_ctrl_sync.sv ====
// Replay control synchronizer
// Brings the start, write-done and software-reset levels onto clk,
// makes edge pulses and holds the replay count and the clear flag

`timescale 1ns/1ps
`default_nettype none

`include "replay_defines.svh"

module replay_ctrl_sync
   import replay_pkg::*;
(
   input  logic        clk,
   input  logic        rst_clk,
   input  logic        start_replay_i,
   input  logic        wr_done_i,
   input  logic        sw_rst_i,
   input  replay_cnt_t replay_count_i,
   output logic        start_p_o,
   output logic        wr_done_p_o,
   output logic        clear_p_o,
   output logic        sw_rst_hold_o,
   output replay_cnt_t replay_count_o
);

   localparam int SL = `REPLAY_SYNC_LEN;

   // Lane order is {sw_rst, wr_done, start} with stage 0 the newest
   logic [SL-1:0][2:0] sync_q;
   logic [2:0]         lvl_now;
   logic [2:0]         lvl_prev;
   logic [2:0]         rise;
   logic               sw_rst_hold_q;
   replay_cnt_t        replay_count_q;

   always_ff @(posedge clk) begin
      if (rst_clk) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[SL-2:0], {sw_rst_i, wr_done_i, start_replay_i}};
      end
   end

   assign lvl_now  = sync_q[SL-2];
   assign lvl_prev = sync_q[SL-1];
   assign rise     = lvl_now & ~lvl_prev;

   assign start_p_o   = rise[0];
   assign wr_done_p_o = rise[1];
   assign clear_p_o   = rise[2];

   always_ff @(posedge clk) begin
      if (rst_clk) begin
         sw_rst_hold_q  <= 1'b0;
         replay_count_q <= '0;
      end else begin
         sw_rst_hold_q <= lvl_now[2];
         // Software reset wins over a start seen in the same cycle
         if (rise[2]) begin
            replay_count_q <= '0;
         end else if (rise[0]) begin
            replay_count_q <= replay_count_i;
         end
      end
   end

   assign sw_rst_hold_o  = sw_rst_hold_q;
   assign replay_count_o = replay_count_q;

endmodule

`default_nettype wire

// ==== hdl/beat_mem.sv ====
// Beat memory
// One write port and one registered read port with a read-valid flag

`timescale 1ns/1ps
`default_nettype none

`include "replay_defines.svh"

module beat_mem
   import replay_pkg::*;
(
   input  logic      clk,
   input  logic      rst_clk,
   input  logic      wr_en_i,
   input  mem_addr_t wr_addr_i,
   input  beat_t     wr_beat_i,
   input  logic      rd_en_i,
   input  mem_addr_t rd_addr_i,
   output logic      rd_valid_o,
   output beat_t     rd_beat_o
);

   beat_t mem_q [0:(1 << `REPLAY_ADDR_W)-1];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem_q[wr_addr_i] <= wr_beat_i;
      end
      if (rd_en_i) begin
         rd_beat_o <= mem_q[rd_addr_i];
      end
   end

   always_ff @(posedge clk) begin
      if (rst_clk) begin
         rd_valid_o <= 1'b0;
      end else begin
         rd_valid_o <= rd_en_i;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/replay_engine.sv ====
// Capture and replay engine
// Writes accepted input beats to the beat memory, then reads the captured
// range back once per pass until the replay count is reached

`timescale 1ns/1ps
`default_nettype none

module replay_engine
   import replay_pkg::*;
(
   input  logic        clk,
   input  logic        rst_clk,
   input  logic        s_valid_i,
   input  logic        s_last_i,
   input  data_t       s_data_i,
   input  keep_t       s_keep_i,
   output logic        s_ready_o,
   input  logic        start_p_i,
   input  logic        wr_done_p_i,
   input  logic        clear_p_i,
   input  logic        sw_rst_hold_i,
   input  replay_cnt_t replay_count_i,
   input  logic        nearly_full_i,
   output logic        wr_en_o,
   output mem_addr_t   wr_addr_o,
   output beat_t       wr_beat_o,
   output logic        rd_en_o,
   output mem_addr_t   rd_addr_o
);

   engine_state_t state_q;
   engine_state_t state_d;
   mem_addr_t     wr_addr_q;
   mem_addr_t     wr_addr_d;
   mem_addr_t     end_addr_q;
   mem_addr_t     rd_addr_q;
   mem_addr_t     rd_addr_d;
   replay_cnt_t   pass_q;
   replay_cnt_t   pass_d;
   replay_cnt_t   pass_inc;
   replay_cnt_t   pass_target;
   logic          captured_q;
   logic          mem_full_q;
   logic          accept;

   assign s_ready_o = (state_q == CAPTURE) && !mem_full_q;
   assign accept    = s_valid_i && s_ready_o;

   assign wr_en_o   = accept;
   assign wr_addr_o = wr_addr_q;
   assign wr_beat_o = {s_last_i, s_keep_i, s_data_i};

   // Only read when the FIFO has room for this beat plus the one in flight
   assign rd_en_o   = (state_q == REPLAY) && !nearly_full_i;
   assign rd_addr_o = rd_addr_q;

   assign pass_inc    = pass_q + 1'b1;
   // A count of zero still plays the capture once
   assign pass_target = (replay_count_i == '0) ? replay_cnt_t'(1) : replay_count_i;

   always_comb begin
      state_d   = state_q;
      wr_addr_d = wr_addr_q;
      rd_addr_d = rd_addr_q;
      pass_d    = pass_q;
      case (state_q)
         IDLE: begin
            if (s_valid_i) begin
               state_d = CAPTURE;
            end else if (start_p_i && captured_q && !sw_rst_hold_i) begin
               state_d   = REPLAY;
               rd_addr_d = '0;
               pass_d    = '0;
            end
         end
         CAPTURE: begin
            if (accept) begin
               wr_addr_d = wr_addr_q + 1'b1;
            end
            // Rewind so the next capture overwrites this one
            if (wr_done_p_i) begin
               state_d   = IDLE;
               wr_addr_d = '0;
            end
         end
         REPLAY: begin
            if (rd_en_o) begin
               rd_addr_d = rd_addr_q + 1'b1;
               if (rd_addr_q == end_addr_q) begin
                  state_d = REPLAY_WRAP;
               end
            end
         end
         REPLAY_WRAP: begin
            pass_d    = pass_inc;
            rd_addr_d = '0;
            state_d   = (pass_inc >= pass_target) ? IDLE : REPLAY;
         end
         default: begin
            state_d = IDLE;
         end
      endcase
      // Software reset aborts whatever is running
      if (clear_p_i) begin
         state_d   = IDLE;
         wr_addr_d = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_clk) begin
         state_q    <= IDLE;
         wr_addr_q  <= '0;
         rd_addr_q  <= '0;
         pass_q     <= '0;
         end_addr_q <= '0;
         captured_q <= 1'b0;
         mem_full_q <= 1'b0;
      end else begin
         state_q   <= state_d;
         wr_addr_q <= wr_addr_d;
         rd_addr_q <= rd_addr_d;
         pass_q    <= pass_d;
         if (accept) begin
            end_addr_q <= wr_addr_q;
            captured_q <= 1'b1;
         end
         // Writing the top address fills the memory
         if (accept && (wr_addr_q == '1)) begin
            mem_full_q <= 1'b1;
         end
         if (wr_done_p_i || clear_p_i) begin
            mem_full_q <= 1'b0;
         end
         if (clear_p_i) begin
            captured_q <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== hdl/replay_out_fifo.sv ====
// Output beat FIFO
// Fall-through queue between the memory read port and the output stream,
// with a nearly-full flag that throttles the reads

`timescale 1ns/1ps
`default_nettype none

`include "replay_defines.svh"

module replay_out_fifo
   import replay_pkg::*;
(
   input  logic  clk,
   input  logic  rst_clk,
   input  logic  wr_en_i,
   input  beat_t wr_beat_i,
   input  logic  m_ready_i,
   output logic  m_valid_o,
   output beat_t m_beat_o,
   output logic  nearly_full_o
);

   localparam int AW    = `REPLAY_FIFO_AW;
   localparam int DEPTH = 1 << AW;
   localparam logic [AW:0] FULL_LEVEL = (AW+1)'(DEPTH);
   localparam logic [AW:0] NF_LEVEL   = (AW+1)'(DEPTH - `REPLAY_FIFO_SLACK);

   beat_t         mem_q [0:DEPTH-1];
   logic [AW-1:0] wr_ptr_q;
   logic [AW-1:0] rd_ptr_q;
   logic [AW:0]   count_q;
   logic          full;
   logic          push;
   logic          pop;

   assign full  = (count_q == FULL_LEVEL);
   assign push  = wr_en_i && !full;
   assign pop   = m_valid_o && m_ready_i;

   assign m_valid_o     = (count_q != '0);
   assign m_beat_o      = mem_q[rd_ptr_q];
   assign nearly_full_o = (count_q >= NF_LEVEL);

   always_ff @(posedge clk) begin
      if (push) begin
         mem_q[wr_ptr_q] <= wr_beat_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_clk) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         if (push && !pop) begin
            count_q <= count_q + 1'b1;
         end else if (pop && !push) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== hdl/pkt_replay_top.sv ====
// Packet capture and replay top level
// Connects the control synchronizer, engine, beat memory and output FIFO

`timescale 1ns/1ps
`default_nettype none

module pkt_replay_top
   import replay_pkg::*;
(
   input  logic        clk,
   input  logic        rst_clk,
   input  logic        s_valid_i,
   input  data_t       s_data_i,
   input  keep_t       s_keep_i,
   input  logic        s_last_i,
   output logic        s_ready_o,
   output logic        m_valid_o,
   output data_t       m_data_o,
   output keep_t       m_keep_o,
   output logic        m_last_o,
   input  logic        m_ready_i,
   input  logic        start_replay_i,
   input  logic        wr_done_i,
   input  logic        sw_rst_i,
   input  replay_cnt_t replay_count_i
);

   logic        start_p;
   logic        wr_done_p;
   logic        clear_p;
   logic        sw_rst_hold;
   replay_cnt_t replay_count;
   logic        nearly_full;
   logic        wr_en;
   mem_addr_t   wr_addr;
   beat_t       wr_beat;
   logic        rd_en;
   mem_addr_t   rd_addr;
   logic        rd_valid;
   beat_t       rd_beat;
   beat_t       m_beat;

   replay_ctrl_sync i_ctrl_sync (
      .clk            (clk),
      .rst_clk        (rst_clk),
      .start_replay_i (start_replay_i),
      .wr_done_i      (wr_done_i),
      .sw_rst_i       (sw_rst_i),
      .replay_count_i (replay_count_i),
      .start_p_o      (start_p),
      .wr_done_p_o    (wr_done_p),
      .clear_p_o      (clear_p),
      .sw_rst_hold_o  (sw_rst_hold),
      .replay_count_o (replay_count)
   );

   replay_engine i_engine (
      .clk            (clk),
      .rst_clk        (rst_clk),
      .s_valid_i      (s_valid_i),
      .s_last_i       (s_last_i),
      .s_data_i       (s_data_i),
      .s_keep_i       (s_keep_i),
      .s_ready_o      (s_ready_o),
      .start_p_i      (start_p),
      .wr_done_p_i    (wr_done_p),
      .clear_p_i      (clear_p),
      .sw_rst_hold_i  (sw_rst_hold),
      .replay_count_i (replay_count),
      .nearly_full_i  (nearly_full),
      .wr_en_o        (wr_en),
      .wr_addr_o      (wr_addr),
      .wr_beat_o      (wr_beat),
      .rd_en_o        (rd_en),
      .rd_addr_o      (rd_addr)
   );

   beat_mem i_beat_mem (
      .clk        (clk),
      .rst_clk    (rst_clk),
      .wr_en_i    (wr_en),
      .wr_addr_i  (wr_addr),
      .wr_beat_i  (wr_beat),
      .rd_en_i    (rd_en),
      .rd_addr_i  (rd_addr),
      .rd_valid_o (rd_valid),
      .rd_beat_o  (rd_beat)
   );

   replay_out_fifo i_out_fifo (
      .clk           (clk),
      .rst_clk       (rst_clk),
      .wr_en_i       (rd_valid),
      .wr_beat_i     (rd_beat),
      .m_ready_i     (m_ready_i),
      .m_valid_o     (m_valid_o),
      .m_beat_o      (m_beat),
      .nearly_full_o (nearly_full)
   );

   assign {m_last_o, m_keep_o, m_data_o} = m_beat;

endmodule

`default_nettype wire

// ==== verification/tb_pkt_replay.sv ====
// Packet replay testbench
// Captures random packets, replays them under several counts and output
// back-pressure, and compares every replayed beat with a queue model

`timescale 1ns/1ps
`default_nettype none

module tb_pkt_replay
   import replay_pkg::*;
();

   localparam int          CLK_PERIOD   = 40;
   localparam int          DRIVE_DELAY  = 2;
   localparam int          RESET_CYCLES = 16;
   localparam logic [31:0] SEED         = 32'hacea_5d0c;
   localparam int          NUM_PKTS     = 4;
   localparam int          MAX_PKT_LEN  = 8;
   localparam int          MAX_CAP      = NUM_PKTS * MAX_PKT_LEN;
   localparam int          CTRL_HOLD    = 6;
   localparam int          QUIET_CYCLES = 64;
   localparam int          IDLE_WINDOW  = MAX_CAP * 40;
   // Two captures, seven replay passes and the blocked replay window
   localparam int          TOTAL_BEATS  = MAX_CAP * 9 + MAX_CAP;
   localparam int          TIMEOUT_CYC  = TOTAL_BEATS * 40 + 4000;

   localparam int CTRL_START   = 0;
   localparam int CTRL_WR_DONE = 1;
   localparam int CTRL_SW_RST  = 2;

   logic        clk;
   logic        rst_clk;
   logic        s_valid_i;
   data_t       s_data_i;
   keep_t       s_keep_i;
   logic        s_last_i;
   logic        s_ready_o;
   logic        m_valid_o;
   data_t       m_data_o;
   keep_t       m_keep_o;
   logic        m_last_o;
   logic        m_ready_i;
   logic        start_replay_i;
   logic        wr_done_i;
   logic        sw_rst_i;
   replay_cnt_t replay_count_i;

   logic [31:0] stim_rng;
   logic [31:0] ready_rng;
   logic        ready_random;
   beat_t       cap_q[$];
   beat_t       rx_q[$];
   int          test_num;
   int          tests_failed;
   int          checks;
   int          errors;
   int          test_err_base;

   pkt_replay_top i_dut (
      .clk            (clk),
      .rst_clk        (rst_clk),
      .s_valid_i      (s_valid_i),
      .s_data_i       (s_data_i),
      .s_keep_i       (s_keep_i),
      .s_last_i       (s_last_i),
      .s_ready_o      (s_ready_o),
      .m_valid_o      (m_valid_o),
      .m_data_o       (m_data_o),
      .m_keep_o       (m_keep_o),
      .m_last_o       (m_last_o),
      .m_ready_i      (m_ready_i),
      .start_replay_i (start_replay_i),
      .wr_done_i      (wr_done_i),
      .sw_rst_i       (sw_rst_i),
      .replay_count_i (replay_count_i)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] draw_stim();
      stim_rng = lcg_step(stim_rng);
      return stim_rng;
   endfunction

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("CHECK FAILED %s expected 0x%0h actual 0x%0h at %0t",
                  name, expected, actual, $time);
      end
   endtask

   task automatic step_cycle();
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic set_control(input int sel, input logic level);
      case (sel)
         CTRL_START:   start_replay_i = level;
         CTRL_WR_DONE: wr_done_i      = level;
         default:      sw_rst_i       = level;
      endcase
   endtask

   // Long enough for the synchronizer to see both edges
   task automatic pulse_control(input int sel);
      set_control(sel, 1'b1);
      repeat (CTRL_HOLD) step_cycle();
      set_control(sel, 1'b0);
      repeat (CTRL_HOLD) step_cycle();
   endtask

   task automatic send_beat(input beat_t beat);
      int   gap;
      logic accepted;
      gap = int'(draw_stim() >> 30);
      repeat (gap) step_cycle();
      {s_last_i, s_keep_i, s_data_i} = beat;
      s_valid_i = 1'b1;
      accepted = 1'b0;
      while (!accepted) begin
         @(negedge clk);
         accepted = s_ready_o;
         step_cycle();
      end
      s_valid_i = 1'b0;
   endtask

   task automatic capture_packets();
      int          len;
      logic [31:0] r_hi;
      logic [31:0] r_lo;
      logic [31:0] r_keep;
      logic        last_b;
      beat_t       beat;
      cap_q.delete();
      for (int p = 0; p < NUM_PKTS; p++) begin
         len = 1 + int'(draw_stim() >> 29);
         for (int b = 0; b < len; b++) begin
            r_hi   = draw_stim();
            r_lo   = draw_stim();
            r_keep = draw_stim();
            last_b = (b == len - 1);
            beat   = {last_b, r_keep[31:24], r_hi, r_lo};
            send_beat(beat);
            cap_q.push_back(beat);
         end
      end
      pulse_control(CTRL_WR_DONE);
   endtask

   task automatic wait_for_beats(input int base, input int n);
      int waited;
      waited = 0;
      while ((rx_q.size() - base) < n && waited < n * 40 + 200) begin
         step_cycle();
         waited++;
      end
      if ((rx_q.size() - base) < n) begin
         errors++;
         $display("Timed out waiting for replayed beats: expected %0d, received %0d",
                  n, rx_q.size() - base);
      end
   endtask

   task automatic finish_test(input string name);
      test_num++;
      if (errors == test_err_base) begin
         $display("Test %0d %s: ok", test_num, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: %0d errors", test_num, name, errors - test_err_base);
      end
      test_err_base = errors;
   endtask

   // Expected output is the captured queue repeated max(count, 1) times
   task automatic run_replay(input int count, input string name);
      int    passes;
      int    n;
      int    base;
      beat_t exp_b;
      beat_t act_b;
      passes = (count > 1) ? count : 1;
      n      = cap_q.size() * passes;
      base   = rx_q.size();
      replay_count_i = replay_cnt_t'(count);
      pulse_control(CTRL_START);
      wait_for_beats(base, n);
      repeat (QUIET_CYCLES) step_cycle();
      check_value("replayed beat count", 64'(n), 64'(rx_q.size() - base));
      for (int i = 0; i < n && i < rx_q.size() - base; i++) begin
         exp_b = cap_q[i % cap_q.size()];
         act_b = rx_q[base + i];
         check_value("m_data_o", 64'(exp_b[63:0]), 64'(act_b[63:0]));
         check_value("m_keep_o", 64'(exp_b[71:64]), 64'(act_b[71:64]));
         check_value("m_last_o", 64'(exp_b[72]), 64'(act_b[72]));
      end
      finish_test(name);
   endtask

   // Output monitor that records each beat transferred on the next edge
   initial begin
      forever begin
         @(negedge clk);
         if (!rst_clk && m_valid_o && m_ready_i) begin
            rx_q.push_back({m_last_o, m_keep_o, m_data_o});
         end
      end
   end

   initial begin
      m_ready_i = 1'b0;
      ready_rng = ~SEED;
      forever begin
         @(posedge clk);
         #DRIVE_DELAY;
         if (ready_random) begin
            ready_rng = lcg_step(ready_rng);
            m_ready_i = (ready_rng[31:29] < 3'd3);
         end else begin
            m_ready_i = 1'b1;
         end
      end
   end

   initial begin
      repeat (TIMEOUT_CYC) @(posedge clk);
      $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYC);
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      int base;
      rst_clk        = 1'b1;
      s_valid_i      = 1'b0;
      s_data_i       = '0;
      s_keep_i       = '0;
      s_last_i       = 1'b0;
      start_replay_i = 1'b0;
      wr_done_i      = 1'b0;
      sw_rst_i       = 1'b0;
      replay_count_i = '0;
      ready_random   = 1'b0;
      stim_rng       = SEED;
      test_num       = 0;
      tests_failed   = 0;
      checks         = 0;
      errors         = 0;
      test_err_base  = 0;

      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      rst_clk = 1'b0;
      check_value("s_ready_o", 64'(0), 64'(s_ready_o));
      check_value("m_valid_o", 64'(0), 64'(m_valid_o));

      capture_packets();
      run_replay(1, "single pass");
      run_replay(3, "three passes");
      run_replay(0, "count of zero");

      ready_random = 1'b1;
      run_replay(1, "output back-pressure");
      ready_random = 1'b0;

      // Software reset drops the capture, so this start must do nothing
      pulse_control(CTRL_SW_RST);
      base = rx_q.size();
      replay_count_i = replay_cnt_t'(1);
      pulse_control(CTRL_START);
      repeat (IDLE_WINDOW) step_cycle();
      check_value("beats after software reset", 64'(0), 64'(rx_q.size() - base));
      finish_test("replay blocked after software reset");

      capture_packets();
      run_replay(1, "fresh capture after software reset");

      $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
               test_num, tests_failed, checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hdl
hdl/replay_pkg.sv
hdl/replay_ctrl_sync.sv
hdl/beat_mem.sv
hdl/replay_engine.sv
hdl/replay_out_fifo.sv
hdl/pkt_replay_top.sv
verification/tb_pkt_replay.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the packet replay testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 -f src.f --top-module tb_pkt_replay -o tb_pkt_replay

./obj_dir/tb_pkt_replay > sim.log 2>&1
cat sim.log

if grep -q ">>> FAIL" sim.log; then
   echo "Simulation reported a failure, see sim.log"
   exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
   echo "Simulation ended without a result, see sim.log"
   exit 1
fi
echo "Simulation finished cleanly"
